// ==== design/ciph_core_top.sv ====
/* Redundant cipher round controller */

`timescale 1ns/100ps
`default_nettype none

module ciph_core_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  input  ciph_pkg::sp2v_e                in_valid_i,
  output logic                           in_ready_o,
  input  ciph_pkg::ciph_op_e             op_i,
  input  ciph_pkg::key_len_e             key_len_i,
  input  logic [ciph_pkg::DataWidth-1:0] data_i,

  output ciph_pkg::sp2v_e                out_valid_o,
  input  ciph_pkg::sp2v_e                out_ready_i,
  output logic [ciph_pkg::DataWidth-1:0] data_o,

  input  logic                           alert_fatal_i,
  output logic                           alert_o
);

  logic alert_q;
  logic in_enc_err, out_enc_err, mr_err;

  ciph_job_if in_job ();     // Intake to FIFO
  ciph_job_if ctrl_job ();   // FIFO to controller

  ciph_req_intake u_intake (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .in_valid_i ( in_valid_i ),
    .in_ready_o ( in_ready_o ),
    .op_i       ( op_i       ),
    .key_len_i  ( key_len_i  ),
    .data_i     ( data_i     ),
    .alert_i    ( alert_q    ),
    .enc_err_o  ( in_enc_err ),
    .job_o      ( in_job     )
  );

  ciph_job_fifo u_fifo (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .wr     ( in_job   ),
    .rd     ( ctrl_job )
  );

  ciph_round_ctrl u_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .job_i       ( ctrl_job    ),
    .out_ready_i ( out_ready_i ),
    .out_valid_o ( out_valid_o ),
    .data_o      ( data_o      ),
    .alert_i     ( alert_q     ),
    .enc_err_o   ( out_enc_err ),
    .mr_err_o    ( mr_err      )
  );

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else if (in_enc_err || out_enc_err || mr_err || alert_fatal_i) begin
      alert_q <= 1'b1;
    end
  end

  assign alert_o = alert_q;

endmodule

`default_nettype wire

// ==== design/ciph_job_fifo.sv ====
/* Two-entry job FIFO */

`timescale 1ns/100ps
`default_nettype none

module ciph_job_fifo (
  input  logic    clk_i,
  input  logic    rst_ni,

  ciph_job_if.dst wr,
  ciph_job_if.src rd
);
  import ciph_pkg::*;

  ciph_op_e             op_mem      [2];
  key_len_e             key_len_mem [2];
  logic [DataWidth-1:0] data_mem    [2];

  logic       wr_ptr_q, rd_ptr_q;
  logic [1:0] cnt_q, cnt_d;
  logic       ready_q;   // Low through reset, opens one edge later
  logic       wr_en, rd_en;

  assign wr_en = wr.valid && wr.ready;
  assign rd_en = rd.valid && rd.ready;

  assign cnt_d = cnt_q + {1'b0, wr_en} - {1'b0, rd_en};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
      ready_q  <= 1'b0;
    end else begin
      if (wr_en) wr_ptr_q <= ~wr_ptr_q;
      if (rd_en) rd_ptr_q <= ~rd_ptr_q;
      cnt_q   <= cnt_d;
      ready_q <= (cnt_d != 2'd2);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      op_mem[wr_ptr_q]      <= wr.op;
      key_len_mem[wr_ptr_q] <= wr.key_len;
      data_mem[wr_ptr_q]    <= wr.data;
    end
  end

  assign wr.ready   = ready_q;
  assign rd.valid   = (cnt_q != 2'd0);
  assign rd.op      = op_mem[rd_ptr_q];
  assign rd.key_len = key_len_mem[rd_ptr_q];
  assign rd.data    = data_mem[rd_ptr_q];

  // Registered ready must track the fill count
  a_no_write_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cnt_q == 2'd2) |-> !wr_en
  );

endmodule

`default_nettype wire

// ==== design/ciph_job_if.sv ====
/* Cipher job link */

`timescale 1ns/100ps
`default_nettype none

interface ciph_job_if;
  import ciph_pkg::*;

  logic                 valid;
  logic                 ready;
  ciph_op_e             op;
  key_len_e             key_len;
  logic [DataWidth-1:0] data;

  // Producer side of a link
  modport src (
    output valid,
    output op,
    output key_len,
    output data,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  op,
    input  key_len,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

// ==== design/ciph_pkg.sv ====
/* Cipher round controller package */

`default_nettype none

package ciph_pkg;

  localparam int unsigned DataWidth   = 32;
  localparam int unsigned RndCtrWidth = 4;
  localparam int unsigned NumRails    = 2;

  // Two-bit sparse strobe, 00 and 11 are invalid
  typedef enum logic [1:0] {
    SP2V_HIGH = 2'b10,
    SP2V_LOW  = 2'b01
  } sp2v_e;

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  typedef enum logic [1:0] {
    KEY_128 = 2'b00,
    KEY_192 = 2'b01,
    KEY_256 = 2'b10
  } key_len_e;

  // Round count per key length, unknown code runs like KEY_128
  function automatic logic [RndCtrWidth-1:0] rounds_for(key_len_e key_len);
    logic [RndCtrWidth-1:0] num;
    case (key_len)
      KEY_192: num = RndCtrWidth'(12);
      KEY_256: num = RndCtrWidth'(14);
      default: num = RndCtrWidth'(10);
    endcase
    return num;
  endfunction

  // Rotate left, then mix in the round index
  function automatic logic [DataWidth-1:0] fwd_round(logic [DataWidth-1:0] data,
                                                     logic [RndCtrWidth-1:0] rnd);
    logic [DataWidth-1:0] rot;
    rot = {data[DataWidth-2:0], data[DataWidth-1]};
    return rot ^ DataWidth'(rnd);
  endfunction

  // Exact inverse of fwd_round for the same index
  function automatic logic [DataWidth-1:0] inv_round(logic [DataWidth-1:0] data,
                                                     logic [RndCtrWidth-1:0] rnd);
    logic [DataWidth-1:0] mix;
    mix = data ^ DataWidth'(rnd);
    return {mix[0], mix[DataWidth-1:1]};
  endfunction

endpackage

`default_nettype wire

// ==== design/ciph_req_intake.sv ====
/* Request intake */

`timescale 1ns/100ps
`default_nettype none

module ciph_req_intake (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  input  ciph_pkg::sp2v_e                in_valid_i,
  output logic                           in_ready_o,
  input  ciph_pkg::ciph_op_e             op_i,
  input  ciph_pkg::key_len_e             key_len_i,
  input  logic [ciph_pkg::DataWidth-1:0] data_i,

  input  logic                           alert_i,
  output logic                           enc_err_o,

  ciph_job_if.src                        job_o
);
  import ciph_pkg::*;

  logic in_high;

  //////////////////////////////////////////////////
  // Strobe decode
  //////////////////////////////////////////////////

  // Only an exact HIGH code counts as a request
  assign in_high   = (in_valid_i == SP2V_HIGH);
  assign enc_err_o = !(in_valid_i inside {SP2V_HIGH, SP2V_LOW});

  //////////////////////////////////////////////////
  // Job forwarding
  //////////////////////////////////////////////////

  assign job_o.valid   = in_high && !alert_i;
  assign job_o.op      = op_i;
  assign job_o.key_len = key_len_i;
  assign job_o.data    = data_i;

  assign in_ready_o = job_o.ready && !alert_i;   // Closed for good once alerted

  // Operation must be known whenever a request is presented
  a_op_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_high |-> !$isunknown(op_i)
  );

endmodule

`default_nettype wire

// ==== design/ciph_round_ctrl.sv ====
/* Dual-rail round controller */

`timescale 1ns/100ps
`default_nettype none

module ciph_round_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  ciph_job_if.dst                        job_i,

  input  ciph_pkg::sp2v_e                out_ready_i,
  output ciph_pkg::sp2v_e                out_valid_o,
  output logic [ciph_pkg::DataWidth-1:0] data_o,

  input  logic                           alert_i,
  output logic                           enc_err_o,
  output logic                           mr_err_o
);
  import ciph_pkg::*;

  sp2v_e                                out_ready;
  logic                                 start;
  logic [NumRails-1:0]                  sp_start, sp_out_ready, sp_out_valid;
  logic [NumRails-1:0]                  mr_busy, mr_done, mr_load, mr_step;
  logic [NumRails-1:0][RndCtrWidth-1:0] mr_rnd_ctr;
  logic [RndCtrWidth-1:0]               rnd_ctr;
  logic                                 busy, done, load, step;
  logic                                 mr_err;
  ciph_op_e                             op_q;
  logic [DataWidth-1:0]                 data_q;

  // Invalid out_ready code is flagged and read as LOW
  assign enc_err_o = !(out_ready_i inside {SP2V_HIGH, SP2V_LOW});
  assign out_ready = (out_ready_i == SP2V_HIGH) ? SP2V_HIGH : SP2V_LOW;

  assign job_i.ready = !busy && !done && !alert_i;
  assign start       = job_i.valid && job_i.ready;

  assign sp_start     = start ? SP2V_HIGH : SP2V_LOW;
  assign sp_out_ready = out_ready;

  //////////////////////////////////////////////////
  // Rails
  //////////////////////////////////////////////////

  // Rail 0 owns the upper strobe bit, rail 1 the inverted lower one
  for (genvar i = 0; i < NumRails; i++) begin : gen_rail
    localparam int unsigned SpBit  = NumRails - 1 - i;
    localparam bit          ActLow = bit'(i);

    logic busy_p, load_p, step_p;

    ciph_round_rail #(
      .ActiveLow   ( ActLow              )
    ) u_rail (
      .clk_i       ( clk_i               ),
      .rst_ni      ( rst_ni              ),
      .start_i     ( sp_start[SpBit]     ),
      .out_ready_i ( sp_out_ready[SpBit] ),
      .key_len_i   ( job_i.key_len       ),
      .op_i        ( job_i.op            ),
      .busy_o      ( busy_p              ),
      .done_o      ( sp_out_valid[SpBit] ), // Sparsified
      .load_o      ( load_p              ),
      .step_o      ( step_p              ),
      .rnd_ctr_o   ( mr_rnd_ctr[i]       )
    );

    assign mr_busy[i] = busy_p ^ ActLow;
    assign mr_done[i] = sp_out_valid[SpBit] ^ ActLow;
    assign mr_load[i] = load_p ^ ActLow;
    assign mr_step[i] = step_p ^ ActLow;
  end

  assign busy = |mr_busy;
  assign done = |mr_done;
  assign load = |mr_load;
  assign step = |mr_step;

  // OR the counters, then compare every rail against the result
  always_comb begin
    rnd_ctr = '0;
    mr_err  = 1'b0;
    for (int i = 0; i < NumRails; i++) begin
      rnd_ctr |= mr_rnd_ctr[i];
    end
    for (int i = 0; i < NumRails; i++) begin
      if (mr_rnd_ctr[i] != rnd_ctr || mr_busy[i] != busy || mr_done[i] != done) begin
        mr_err = 1'b1;
      end
    end
  end

  assign mr_err_o = mr_err;

  //////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q <= CIPH_FWD;
    end else if (load) begin
      op_q <= job_i.op;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= job_i.data;
    end else if (step) begin
      data_q <= (op_q == CIPH_FWD) ? fwd_round(data_q, rnd_ctr) : inv_round(data_q, rnd_ctr);
    end
  end

  assign data_o = data_q;

  // Result withheld on alert or on any rail disagreement
  assign out_valid_o = (alert_i || mr_err) ? SP2V_LOW : sp2v_e'(sp_out_valid);

  // Mismatch check must catch every split done pair
  a_out_valid_code : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid_o inside {SP2V_HIGH, SP2V_LOW}
  );

endmodule

`default_nettype wire

// ==== design/ciph_round_rail.sv ====
/* Single-rail round FSM */

`timescale 1ns/100ps
`default_nettype none

module ciph_round_rail #(
  parameter bit ActiveLow = 1'b0
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic                             start_i,
  input  logic                             out_ready_i,
  input  ciph_pkg::key_len_e               key_len_i,
  input  ciph_pkg::ciph_op_e               op_i,

  output logic                             busy_o,
  output logic                             done_o,
  output logic                             load_o,
  output logic                             step_o,
  output logic [ciph_pkg::RndCtrWidth-1:0] rnd_ctr_o
);
  import ciph_pkg::*;

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    ROUND = 2'b01,
    DONE  = 2'b10
  } rail_state_e;

  rail_state_e            state_q, state_d;
  logic [RndCtrWidth-1:0] ctr_q, ctr_d;
  ciph_op_e               op_q;
  key_len_e               key_len_q;
  logic                   start, out_ready;
  logic                   load, step, last_rnd;

  // Back to active-high inside the rail
  assign start     = start_i ^ ActiveLow;
  assign out_ready = out_ready_i ^ ActiveLow;

  // Forward counts up to N-1, inverse counts down to 0
  assign last_rnd = (op_q == CIPH_FWD) ?
                    (ctr_q == rounds_for(key_len_q) - RndCtrWidth'(1)) : (ctr_q == '0);

  always_comb begin
    state_d = state_q;
    ctr_d   = ctr_q;
    load    = 1'b0;
    step    = 1'b0;
    case (state_q)
      IDLE: begin
        if (start) begin
          load    = 1'b1;
          ctr_d   = (op_i == CIPH_FWD) ? '0 : rounds_for(key_len_i) - RndCtrWidth'(1);
          state_d = ROUND;
        end
      end
      ROUND: begin
        step = 1'b1;
        if (last_rnd) begin
          state_d = DONE;
        end else begin
          ctr_d = (op_q == CIPH_FWD) ? ctr_q + RndCtrWidth'(1) : ctr_q - RndCtrWidth'(1);
        end
      end
      DONE: begin
        if (out_ready) begin
          state_d = IDLE;
          ctr_d   = '0;
        end
      end
      default: state_d = IDLE;   // Stray code falls back to idle
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      ctr_q     <= '0;
      op_q      <= CIPH_FWD;
      key_len_q <= KEY_128;
    end else begin
      state_q <= state_d;
      ctr_q   <= ctr_d;
      if (load) begin
        op_q      <= op_i;
        key_len_q <= key_len_i;
      end
    end
  end

  assign busy_o    = (state_q == ROUND) ^ ActiveLow;
  assign done_o    = (state_q == DONE) ^ ActiveLow;
  assign load_o    = load ^ ActiveLow;
  assign step_o    = step ^ ActiveLow;
  assign rnd_ctr_o = ctr_q;

endmodule

`default_nettype wire

// ==== verif/tb_ciph_core.sv ====
/* Cipher round controller testbench */

`timescale 1ns/100ps
`default_nettype none

module tb_ciph_core;
  import ciph_pkg::*;

  localparam int NumPairs      = 4;
  localparam int NumBurst      = 8;
  localparam int NumJobs       = 3 + 2 * NumPairs + NumBurst + 2;
  localparam int MaxStall      = 12;
  localparam int Margin        = 400;   // Resets and locked windows
  localparam int TimeoutCycles = NumJobs * (14 + 4 + MaxStall) + Margin;

  logic                 clk_i;
  logic                 rst_ni;
  sp2v_e                in_valid_i;
  logic                 in_ready_o;
  ciph_op_e             op_i;
  key_len_e             key_len_i;
  logic [DataWidth-1:0] data_i;
  sp2v_e                out_valid_o;
  sp2v_e                out_ready_i;
  logic [DataWidth-1:0] data_o;
  logic                 alert_fatal_i;
  logic                 alert_o;

  logic [DataWidth-1:0] exp_q[$];   // Results still owed in arrival order
  logic                 full_seen;
  int                   cycle_cnt;
  int unsigned          seed_ret;

  ciph_core_top uut (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .in_valid_i    ( in_valid_i    ),
    .in_ready_o    ( in_ready_o    ),
    .op_i          ( op_i          ),
    .key_len_i     ( key_len_i     ),
    .data_i        ( data_i        ),
    .out_valid_o   ( out_valid_o   ),
    .out_ready_i   ( out_ready_i   ),
    .data_o        ( data_o        ),
    .alert_fatal_i ( alert_fatal_i ),
    .alert_o       ( alert_o       )
  );

  always #5 clk_i = ~clk_i;

  // Watchdog
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout, the run did not finish within %0d cycles", TimeoutCycles);
      $display("Something failed");
      $fatal(1, "watchdog expired");
    end
  end

  //////////////////////////////////////////////////
  // Reference model and checking
  //////////////////////////////////////////////////

  // Forward rotates left and mixes in the round index
  // Inverse undoes the rounds in reverse order
  function automatic logic [DataWidth-1:0] expected_result(ciph_op_e op, key_len_e klen,
                                                           logic [DataWidth-1:0] d);
    int                   n;
    logic [DataWidth-1:0] w;
    n = (klen == KEY_192) ? 12 : (klen == KEY_256) ? 14 : 10;
    w = d;
    if (op == CIPH_FWD) begin
      for (int r = 0; r < n; r++) begin
        w = {w[30:0], w[31]} ^ 32'(r);
      end
    end else begin
      for (int r = n - 1; r >= 0; r--) begin
        w = w ^ 32'(r);
        w = {w[0], w[31:1]};
      end
    end
    return w;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_run(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("Something failed");
    $fatal(1, "test error");
  endtask

  //////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni        <= 1'b0;
    in_valid_i    <= SP2V_LOW;
    out_ready_i   <= SP2V_LOW;
    alert_fatal_i <= 1'b0;
    exp_q.delete();
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    check_val("in_ready_o", in_ready_o, 1'b0);
    check_val("out_valid_o", out_valid_o, SP2V_LOW);
    check_val("alert_o", alert_o, 1'b0);
    @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_val("in_ready_o", in_ready_o, 1'b0);   // Opens one edge after release
    @(negedge clk_i);
    check_val("in_ready_o", in_ready_o, 1'b1);
  endtask

  task automatic send_job(input ciph_op_e op, input key_len_e klen,
                          input logic [DataWidth-1:0] d);
    exp_q.push_back(expected_result(op, klen, d));
    @(posedge clk_i);
    in_valid_i <= SP2V_HIGH;
    op_i       <= op;
    key_len_i  <= klen;
    data_i     <= d;
    do @(negedge clk_i); while (!in_ready_o);
    @(posedge clk_i);
    in_valid_i <= SP2V_LOW;   // Taken on this edge
  endtask

  // Wait for a result and hold it off before taking it
  task automatic collect(input int stall, output logic [DataWidth-1:0] got);
    logic [DataWidth-1:0] exp;
    do @(negedge clk_i); while (out_valid_o != SP2V_HIGH);
    repeat (stall) begin
      if (!in_ready_o) full_seen = 1'b1;
      @(negedge clk_i);
      check_val("out_valid_o", out_valid_o, SP2V_HIGH);
    end
    if (exp_q.size() == 0) fail_run("a result came out with no job outstanding");
    exp = exp_q.pop_front();
    check_val("data_o", data_o, exp);
    got = data_o;
    @(posedge clk_i);
    out_ready_i <= SP2V_HIGH;
    @(posedge clk_i);
    out_ready_i <= SP2V_LOW;
  endtask

  task automatic expect_locked(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_val("alert_o", alert_o, 1'b1);
      check_val("in_ready_o", in_ready_o, 1'b0);
      check_val("out_valid_o", out_valid_o, SP2V_LOW);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_fwd_key_lengths();
    logic [DataWidth-1:0] got;
    send_job(CIPH_FWD, KEY_128, $urandom());
    collect(2, got);
    send_job(CIPH_FWD, KEY_192, $urandom());
    collect(2, got);
    send_job(CIPH_FWD, KEY_256, $urandom());
    collect(2, got);
  endtask

  task automatic test_inverse_roundtrip();
    logic [DataWidth-1:0] word, fwd, back;
    key_len_e             klen;
    for (int i = 0; i < NumPairs; i++) begin
      word = $urandom();
      klen = key_len_e'($urandom_range(0, 2));
      send_job(CIPH_FWD, klen, word);
      collect(0, fwd);
      send_job(CIPH_INV, klen, fwd);
      collect(0, back);
      check_val("data_o", back, word);   // Must undo the forward pass
    end
  endtask

  task automatic test_burst_stalls();
    logic [DataWidth-1:0] got;
    full_seen = 1'b0;
    fork
      begin
        for (int i = 0; i < NumBurst; i++) begin
          send_job(ciph_op_e'($urandom_range(0, 1)), key_len_e'($urandom_range(0, 2)),
                   $urandom());
        end
      end
      begin
        for (int j = 0; j < NumBurst; j++) begin
          collect((j == 0) ? MaxStall : $urandom_range(0, MaxStall / 2), got);
        end
      end
    join
    if (!full_seen) fail_run("in_ready_o never dropped while the output was stalled");
  endtask

  task automatic test_bad_in_code(input logic [1:0] code);
    @(posedge clk_i);
    in_valid_i <= sp2v_e'(code);
    @(posedge clk_i);
    in_valid_i <= SP2V_LOW;
    @(negedge clk_i);
    check_val("alert_o", alert_o, 1'b1);
    @(posedge clk_i);
    in_valid_i <= SP2V_HIGH;   // Request while alerted goes nowhere
    op_i       <= CIPH_FWD;
    data_i     <= $urandom();
    expect_locked(20);
    apply_reset();
  endtask

  task automatic test_fatal_during_job();
    send_job(CIPH_FWD, KEY_256, $urandom());
    repeat (4) @(posedge clk_i);
    alert_fatal_i <= 1'b1;
    @(posedge clk_i);
    alert_fatal_i <= 1'b0;
    out_ready_i   <= SP2V_HIGH;
    expect_locked(30);
    apply_reset();
  endtask

  task automatic test_bad_ready_code();
    send_job(CIPH_FWD, KEY_192, $urandom());
    repeat (3) @(posedge clk_i);
    out_ready_i <= sp2v_e'(2'b11);
    @(posedge clk_i);
    out_ready_i <= SP2V_HIGH;
    expect_locked(30);
    apply_reset();
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    in_valid_i    = SP2V_LOW;
    out_ready_i   = SP2V_LOW;
    op_i          = CIPH_FWD;
    key_len_i     = KEY_128;
    data_i        = '0;
    alert_fatal_i = 1'b0;
    cycle_cnt     = 0;
    full_seen     = 1'b0;
    seed_ret      = $urandom(32'h1cdb_6ea5);

    apply_reset();
    test_fwd_key_lengths();
    test_inverse_roundtrip();
    test_burst_stalls();
    test_bad_in_code(2'b00);
    test_bad_in_code(2'b11);
    test_fatal_during_job();
    test_bad_ready_code();

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/ciph_pkg.sv
design/ciph_job_if.sv
design/ciph_req_intake.sv
design/ciph_job_fifo.sv
design/ciph_round_rail.sv
design/ciph_round_ctrl.sv
design/ciph_core_top.sv
verif/tb_ciph_core.sv
